//--- logic/cpsa_regs.sv
// Chip A register file
`timescale 1ns/1ns

module cpsa_regs import vid_mmr_pkg::*; (
    input  logic      clk,
    input  logic      reg_rst,
    input  logic      ppu1_cs,
    input  bus_wr_t   bus,
    output cpsa_out_t regs,
    output logic      pal_copy
);

    word_t           regs_q [cpsa_num];
    pal_copy_state_t pal_state_q;
    logic            wr_en;
    logic            pal_wr;

    // only the 18 low word addresses exist in the fixed map
    assign wr_en  = ppu1_cs && (bus.addr <= cpsa_ppu_ctrl);
    assign pal_wr = ppu1_cs && (bus.addr == cpsa_pal_base);

    // byte lanes with dsn low take the new data
    function automatic word_t lane_merge(word_t old_q, word_t new_d, logic [1:0] dsn);
        word_t merged;
        merged[15:8] = dsn[1] ? old_q[15:8] : new_d[15:8];
        merged[7:0]  = dsn[0] ? old_q[7:0]  : new_d[7:0];
        return merged;
    endfunction

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            for (int i = 0; i < cpsa_num; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[bus.addr] <= lane_merge(regs_q[bus.addr], bus.data, bus.dsn);
        end
    end

    // palette copy waits for the select to drop so pal_base is settled
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            pal_state_q <= pal_idle;
            pal_copy    <= 1'b0;
        end else begin
            pal_copy <= 1'b0;
            case (pal_state_q)
                pal_idle: begin
                    if (pal_wr) begin
                        pal_state_q <= pal_pending;
                    end
                end
                pal_pending: begin
                    if (!ppu1_cs) begin
                        pal_copy    <= 1'b1;
                        pal_state_q <= pal_idle;
                    end
                end
                default: pal_state_q <= pal_idle;
            endcase
        end
    end

    assign regs.obj_base  = regs_q[cpsa_obj_base];
    assign regs.scr1_base = regs_q[cpsa_scr1_base];
    assign regs.scr2_base = regs_q[cpsa_scr2_base];
    assign regs.scr3_base = regs_q[cpsa_scr3_base];
    assign regs.row_base  = regs_q[cpsa_row_base];
    assign regs.star_base = regs_q[cpsa_star_base];
    assign regs.pal_base  = regs_q[cpsa_pal_base];
    assign regs.hpos1     = regs_q[cpsa_hpos1];
    assign regs.vpos1     = regs_q[cpsa_vpos1];
    assign regs.hpos2     = regs_q[cpsa_hpos2];
    assign regs.vpos2     = regs_q[cpsa_vpos2];
    assign regs.hpos3     = regs_q[cpsa_hpos3];
    assign regs.vpos3     = regs_q[cpsa_vpos3];
    assign regs.hstar1    = regs_q[cpsa_hstar1];
    assign regs.vstar1    = regs_q[cpsa_vstar1];
    assign regs.hstar2    = regs_q[cpsa_hstar2];
    assign regs.vstar2    = regs_q[cpsa_vstar2];
    assign regs.ppu_ctrl  = regs_q[cpsa_ppu_ctrl];

    // the palette engine expects one request per write burst
    pal_copy_single: assert property (
        @(posedge clk) disable iff (reg_rst)
        pal_copy |=> !pal_copy
    ) else $error("pal_copy held high for more than one cycle");

endmodule

//--- logic/cpsb_addr_map.sv
// Chip B address decode
`timescale 1ns/1ns

module cpsb_addr_map import vid_mmr_pkg::*; (
    input  logic      clk,
    input  logic      reg_rst,
    input  logic      cfg_we,
    input  cfg_byte_t cfg_data,
    input  reg_addr_t addr,
    output cpsb_hit_t hit,
    output cpsb_cfg_t cfg
);

    logic [8*cfg_len-1:0] chain_q;
    logic                 addr_valid;

    // new byte enters at position 0, the oldest byte falls off the top
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            chain_q <= cfg_reset;
        end else if (cfg_we) begin
            chain_q <= {chain_q[8*cfg_len-9:0], cfg_data};
        end
    end

    // 0x1f is never a chip B register
    assign addr_valid = (addr != addr_none);

    // the ID address lives in byte 0, the other ten addresses follow byte 1
    for (genvar i = 0; i < hit_count; i++) begin : g_hit
        localparam int byte_idx = (i == hit_id) ? 0 : i + 1;
        reg_addr_t cfg_addr;

        // configured byte address, shifted down to a word address
        assign cfg_addr = chain_q[8*byte_idx+1 +: 5];
        assign hit[i]   = addr_valid && (addr == cfg_addr);
    end

    assign cfg.board_id    = chain_q[8*cfg_board_id +: 8];
    assign cfg.layer_mask0 = chain_q[8*cfg_mask0 +: 8];
    assign cfg.layer_mask1 = chain_q[8*(cfg_mask0+1) +: 8];
    assign cfg.layer_mask2 = chain_q[8*(cfg_mask0+2) +: 8];
    assign cfg.layer_mask3 = chain_q[8*(cfg_mask0+3) +: 8];
    // layer 4 has no byte of its own and shares the layer 3 mask
    assign cfg.layer_mask4 = cfg.layer_mask3;
    assign cfg.game        = chain_q[8*cfg_game +: 6];
    assign cfg.bank_offset = chain_q[8*cfg_bank_offset +: 16];
    assign cfg.bank_mask   = chain_q[8*cfg_bank_mask +: 16];

    // a corrupted byte would silently move registers around
    cfg_data_known: assert property (
        @(posedge clk) disable iff (reg_rst)
        cfg_we |-> !$isunknown(cfg_data)
    ) else $error("cfg_data has unknown bits while cfg_we is high");

endmodule

//--- logic/cpsb_read_mux.sv
// Chip B read data
`timescale 1ns/1ns

module cpsb_read_mux import vid_mmr_pkg::*; (
    input  logic       clk,
    input  logic       reg_rst,
    input  logic       ppu2_cs,
    input  cpsb_hit_t  hit,
    input  cpsb_ctrl_t ctrl,
    input  word_t      mult1,
    input  word_t      mult2,
    input  word_t      rslt0,
    input  word_t      rslt1,
    input  cfg_byte_t  board_id,
    output word_t      mmr_dout
);

    word_t rd_data;

    // anything but a single hit reads as open bus
    always_comb begin
        case (hit)
            cpsb_hit_t'(1) << hit_id:
                rd_data = {4'd0, board_id[7:4], 4'd0, board_id[3:0]};
            cpsb_hit_t'(1) << hit_mult1:    rd_data = mult1;
            cpsb_hit_t'(1) << hit_mult2:    rd_data = mult2;
            cpsb_hit_t'(1) << hit_rslt0:    rd_data = rslt0;
            cpsb_hit_t'(1) << hit_rslt1:    rd_data = rslt1;
            cpsb_hit_t'(1) << hit_layer:    rd_data = ctrl.layer_ctrl;
            cpsb_hit_t'(1) << hit_prio0:    rd_data = ctrl.prio0;
            cpsb_hit_t'(1) << hit_prio1:    rd_data = ctrl.prio1;
            cpsb_hit_t'(1) << hit_prio2:    rd_data = ctrl.prio2;
            cpsb_hit_t'(1) << hit_prio3:    rd_data = ctrl.prio3;
            cpsb_hit_t'(1) << hit_pal_page: rd_data = {10'd0, ctrl.pal_page_en};
            default:                        rd_data = open_bus;
        endcase
    end

    // loaded on every selected cycle, held otherwise
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            mmr_dout <= open_bus;
        end else if (ppu2_cs) begin
            mmr_dout <= rd_data;
        end
    end

    dout_after_reset: assert property (
        @(posedge clk) $fell(reg_rst) |-> (mmr_dout == open_bus)
    ) else $error("mmr_dout is not open bus after reset");

endmodule

//--- logic/cpsb_regs.sv
// Chip B writable registers
`timescale 1ns/1ns

module cpsb_regs import vid_mmr_pkg::*; (
    input  logic       clk,
    input  logic       reg_rst,
    input  logic       ppu2_cs,
    input  bus_wr_t    bus,
    input  cpsb_hit_t  hit,
    output cpsb_ctrl_t ctrl,
    output word_t      mult1,
    output word_t      mult2,
    output word_t      rslt0,
    output word_t      rslt1
);

    logic        wr_en;
    logic [31:0] product;

    // chip B only takes full word writes
    assign wr_en = ppu2_cs && (bus.dsn == 2'b00);

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            mult1            <= '0;
            mult2            <= '0;
            ctrl.layer_ctrl  <= '0;
            ctrl.prio0       <= prio_reset;
            ctrl.prio1       <= prio_reset;
            ctrl.prio2       <= prio_reset;
            ctrl.prio3       <= prio_reset;
            ctrl.pal_page_en <= pal_page_reset;
        end else if (wr_en) begin
            // aliased addresses write every register they hit
            if (hit[hit_mult1]) begin
                mult1 <= bus.data;
            end
            if (hit[hit_mult2]) begin
                mult2 <= bus.data;
            end
            if (hit[hit_layer]) begin
                ctrl.layer_ctrl <= bus.data;
            end
            if (hit[hit_prio0]) begin
                ctrl.prio0 <= bus.data;
            end
            if (hit[hit_prio1]) begin
                ctrl.prio1 <= bus.data;
            end
            if (hit[hit_prio2]) begin
                ctrl.prio2 <= bus.data;
            end
            if (hit[hit_prio3]) begin
                ctrl.prio3 <= bus.data;
            end
            if (hit[hit_pal_page]) begin
                ctrl.pal_page_en <= bus.data[5:0];
            end
        end
    end

    assign product = {16'd0, mult1} * {16'd0, mult2};

    // product trails the operands by one clock
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            rslt0 <= '0;
            rslt1 <= '0;
        end else begin
            rslt0 <= product[15:0];
            rslt1 <= product[31:16];
        end
    end

endmodule

//--- logic/vid_mmr.sv
// Video register block top
`timescale 1ns/1ns

module vid_mmr import vid_mmr_pkg::*; (
    input  logic       clk,
    input  logic       reg_rst,
    input  logic       ppu1_cs,
    input  logic       ppu2_cs,
    input  bus_wr_t    bus,
    input  logic       cfg_we,
    input  cfg_byte_t  cfg_data,
    output word_t      mmr_dout,
    output cpsa_out_t  cpsa,
    output logic       pal_copy,
    output cpsb_ctrl_t ctrl,
    output cpsb_cfg_t  cfg
);

    cpsb_hit_t hit;
    word_t     mult1;
    word_t     mult2;
    word_t     rslt0;
    word_t     rslt1;

    // relocatable window decode
    cpsb_addr_map addr_map_i (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .cfg_we   (cfg_we),
        .cfg_data (cfg_data),
        .addr     (bus.addr),
        .hit      (hit),
        .cfg      (cfg)
    );

    // fixed window, scroll and base registers
    cpsa_regs cpsa_regs_i (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .ppu1_cs  (ppu1_cs),
        .bus      (bus),
        .regs     (cpsa),
        .pal_copy (pal_copy)
    );

    cpsb_regs cpsb_regs_i (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .ppu2_cs  (ppu2_cs),
        .bus      (bus),
        .hit      (hit),
        .ctrl     (ctrl),
        .mult1    (mult1),
        .mult2    (mult2),
        .rslt0    (rslt0),
        .rslt1    (rslt1)
    );

    // only chip B drives the read bus
    cpsb_read_mux read_mux_i (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .ppu2_cs  (ppu2_cs),
        .hit      (hit),
        .ctrl     (ctrl),
        .mult1    (mult1),
        .mult2    (mult2),
        .rslt0    (rslt0),
        .rslt1    (rslt1),
        .board_id (cfg.board_id),
        .mmr_dout (mmr_dout)
    );

endmodule

//--- logic/vid_mmr_pkg.sv
// Video register block definitions
package vid_mmr_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  cfg_byte_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [10:0] cpsb_hit_t;

    typedef enum logic {
        pal_idle,
        pal_pending
    } pal_copy_state_t;

    // configuration chain, byte 0 is the most recently shifted in
    localparam int cfg_len = 21;
    localparam logic [8*cfg_len-1:0] cfg_reset =
        {{(cfg_len-3){8'h00}}, 8'h00, 8'h05, 8'h32};

    // byte positions of the non-address fields in the chain
    localparam int cfg_board_id    = 1;
    localparam int cfg_mask0       = 12;
    localparam int cfg_game        = 16;
    localparam int cfg_bank_offset = 17;
    localparam int cfg_bank_mask   = 19;

    // chip B hit vector bits
    localparam int hit_id       = 0;
    localparam int hit_mult1    = 1;
    localparam int hit_mult2    = 2;
    localparam int hit_rslt0    = 3;
    localparam int hit_rslt1    = 4;
    localparam int hit_layer    = 5;
    localparam int hit_prio0    = 6;
    localparam int hit_prio1    = 7;
    localparam int hit_prio2    = 8;
    localparam int hit_prio3    = 9;
    localparam int hit_pal_page = 10;
    localparam int hit_count    = 11;

    localparam reg_addr_t addr_none      = 5'h1f;
    localparam word_t     prio_reset     = 16'hffff;
    localparam logic [5:0] pal_page_reset = 6'h3f;
    localparam word_t     open_bus       = 16'hffff;

    // chip A fixed map
    localparam int        cpsa_num       = 18;
    localparam reg_addr_t cpsa_obj_base  = 5'h00;
    localparam reg_addr_t cpsa_scr1_base = 5'h01;
    localparam reg_addr_t cpsa_scr2_base = 5'h02;
    localparam reg_addr_t cpsa_scr3_base = 5'h03;
    localparam reg_addr_t cpsa_row_base  = 5'h04;
    localparam reg_addr_t cpsa_pal_base  = 5'h05;
    localparam reg_addr_t cpsa_hpos1     = 5'h06;
    localparam reg_addr_t cpsa_vpos1     = 5'h07;
    localparam reg_addr_t cpsa_hpos2     = 5'h08;
    localparam reg_addr_t cpsa_vpos2     = 5'h09;
    localparam reg_addr_t cpsa_hpos3     = 5'h0a;
    localparam reg_addr_t cpsa_vpos3     = 5'h0b;
    localparam reg_addr_t cpsa_hstar1    = 5'h0c;
    localparam reg_addr_t cpsa_vstar1    = 5'h0d;
    localparam reg_addr_t cpsa_hstar2    = 5'h0e;
    localparam reg_addr_t cpsa_vstar2    = 5'h0f;
    localparam reg_addr_t cpsa_star_base = 5'h10;
    localparam reg_addr_t cpsa_ppu_ctrl  = 5'h11;

    typedef struct packed {
        reg_addr_t  addr;
        logic [1:0] dsn;    // active low byte selects
        word_t      data;
    } bus_wr_t;

    typedef struct packed {
        word_t obj_base;
        word_t scr1_base;
        word_t scr2_base;
        word_t scr3_base;
        word_t row_base;
        word_t star_base;
        word_t pal_base;
        word_t hpos1;
        word_t vpos1;
        word_t hpos2;
        word_t vpos2;
        word_t hpos3;
        word_t vpos3;
        word_t hstar1;
        word_t vstar1;
        word_t hstar2;
        word_t vstar2;
        word_t ppu_ctrl;
    } cpsa_out_t;

    typedef struct packed {
        word_t      layer_ctrl;
        word_t      prio0;
        word_t      prio1;
        word_t      prio2;
        word_t      prio3;
        logic [5:0] pal_page_en;
    } cpsb_ctrl_t;

    typedef struct packed {
        cfg_byte_t  board_id;
        cfg_byte_t  layer_mask0;
        cfg_byte_t  layer_mask1;
        cfg_byte_t  layer_mask2;
        cfg_byte_t  layer_mask3;
        cfg_byte_t  layer_mask4;
        logic [5:0] game;
        word_t      bank_offset;
        word_t      bank_mask;
    } cpsb_cfg_t;

endpackage

//--- verification/vid_mmr_tb.sv
// Video register block testbench
`timescale 1ns/1ns

module vid_mmr_tb import vid_mmr_pkg::*; ();

    logic       clk;
    logic       reg_rst;
    logic       ppu1_cs;
    logic       ppu2_cs;
    bus_wr_t    bus;
    logic       cfg_we;
    cfg_byte_t  cfg_data;
    word_t      mmr_dout;
    cpsa_out_t  cpsa;
    logic       pal_copy;
    cpsb_ctrl_t ctrl;
    cpsb_cfg_t  cfg;

    integer    seed = 32'hfc30_8323;
    int        errors;
    int        checks;
    int        tests;
    int        test_err_start;
    string     test_name;
    cfg_byte_t chain [cfg_len];

    vid_mmr dut_i (.*);

    always #20 clk = ~clk;

    // a copy request only follows a cycle where chip A was deselected
    pal_copy_after_cs_low: assert property (
        @(posedge clk) disable iff (reg_rst)
        $rose(pal_copy) |-> $past(!ppu1_cs)
    ) else begin
        errors++;
        $display("pal_copy rose although ppu1_cs was still high");
    end

    task automatic check_word(string what, word_t exp, word_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic begin_test(string name);
        test_name      = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s: %s", test_name, (errors == test_err_start) ? "pass" : "fail");
    endtask

    // one access, strobe high for exactly one edge
    task automatic bus_write(logic chip_b, reg_addr_t addr, logic [1:0] dsn, word_t data);
        @(posedge clk);
        #2;
        bus     = '{addr: addr, dsn: dsn, data: data};
        ppu1_cs = !chip_b;
        ppu2_cs = chip_b;
        @(posedge clk);
        #2;
        ppu1_cs = 1'b0;
        ppu2_cs = 1'b0;
        bus.dsn = 2'b11;
    endtask

    task automatic chip_b_read(reg_addr_t addr, output word_t data);
        @(posedge clk);
        #2;
        bus     = '{addr: addr, dsn: 2'b11, data: 16'h0000};
        ppu2_cs = 1'b1;
        @(posedge clk);
        #2;
        ppu2_cs = 1'b0;
        data    = mmr_dout;
    endtask

    // the last byte pushed lands in position 0
    task automatic load_chain();
        for (int i = cfg_len - 1; i >= 0; i--) begin
            @(posedge clk);
            #2;
            cfg_we   = 1'b1;
            cfg_data = chain[i];
        end
        @(posedge clk);
        #2;
        cfg_we = 1'b0;
    endtask

    initial begin
        word_t rd;
        word_t op1;
        word_t op2;
        logic [31:0] prod;
        int wait_cnt;
        int pulses;

        clk      = 1'b0;
        reg_rst  = 1'b1;
        ppu1_cs  = 1'b0;
        ppu2_cs  = 1'b0;
        bus      = '{addr: 5'h00, dsn: 2'b11, data: 16'h0000};
        cfg_we   = 1'b0;
        cfg_data = 8'h00;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        repeat (3) @(posedge clk);
        #2;
        reg_rst = 1'b0;

        begin_test("reset");
        check_word("pal_copy", 16'h0000, {15'd0, pal_copy});
        check_word("mmr_dout", open_bus, mmr_dout);
        check_word("prio0", 16'hffff, ctrl.prio0);
        check_word("prio3", 16'hffff, ctrl.prio3);
        check_word("pal_page_en", 16'h003f, {10'd0, ctrl.pal_page_en});
        check_word("obj_base", 16'h0000, cpsa.obj_base);
        chip_b_read(5'h19, rd);
        check_word("id read", 16'h0005, rd);
        end_test();

        begin_test("chip_a_lanes");
        bus_write(1'b0, cpsa_hpos2, 2'b00, 16'h1234);
        check_word("hpos2 full", 16'h1234, cpsa.hpos2);
        bus_write(1'b0, cpsa_hpos2, 2'b01, 16'habcd);
        check_word("hpos2 high lane", 16'hab34, cpsa.hpos2);
        bus_write(1'b0, cpsa_hpos2, 2'b10, 16'h5678);
        check_word("hpos2 low lane", 16'hab78, cpsa.hpos2);
        bus_write(1'b0, cpsa_ppu_ctrl, 2'b00, 16'h0f0f);
        bus_write(1'b0, cpsa_ppu_ctrl, 2'b01, 16'h9988);
        check_word("ppu_ctrl high lane", 16'h990f, cpsa.ppu_ctrl);
        bus_write(1'b0, cpsa_ppu_ctrl, 2'b10, 16'h7766);
        check_word("ppu_ctrl low lane", 16'h9966, cpsa.ppu_ctrl);
        end_test();

        begin_test("pal_copy");
        @(posedge clk);
        #2;
        bus     = '{addr: cpsa_pal_base, dsn: 2'b00, data: 16'h4c80};
        ppu1_cs = 1'b1;
        repeat (4) begin
            @(posedge clk);
            #2;
            check_word("pal_copy while selected", 16'h0000, {15'd0, pal_copy});
        end
        ppu1_cs  = 1'b0;
        wait_cnt = 0;
        while (!pal_copy && wait_cnt < 10) begin
            @(posedge clk);
            #2;
            wait_cnt++;
        end
        if (!pal_copy) begin
            errors++;
            $display("timeout: pal_copy never rose after ppu1_cs dropped");
        end
        check_word("edges to pulse", 16'd1, 16'(wait_cnt));
        check_word("pal_base at pulse", 16'h4c80, cpsa.pal_base);
        pulses = 0;
        repeat (6) begin
            @(posedge clk);
            #2;
            pulses += pal_copy;
        end
        check_word("extra pulses", 16'd0, 16'(pulses));
        end_test();

        // relocated map used by the remaining tests
        chain = '{8'h32, 8'h5a, 8'h00, 8'h02, 8'h04, 8'h06, 8'h10, 8'h12, 8'h14,
                  8'h16, 8'h18, 8'h1a, 8'h11, 8'h22, 8'h33, 8'h44, 8'h2b, 8'h34,
                  8'h12, 8'hf0, 8'h0f};
        load_chain();

        begin_test("multiplier");
        repeat (3) begin
            op1  = $random(seed);
            op2  = $random(seed);
            prod = op1 * op2;
            bus_write(1'b1, 5'h00, 2'b00, op1);
            bus_write(1'b1, 5'h01, 2'b00, op2);
            @(posedge clk);
            chip_b_read(5'h00, rd);
            check_word("mult1", op1, rd);
            chip_b_read(5'h02, rd);
            check_word("product low", prod[15:0], rd);
            chip_b_read(5'h03, rd);
            check_word("product high", prod[31:16], rd);
        end
        end_test();

        begin_test("relocation");
        bus_write(1'b1, 5'h08, 2'b00, 16'h0f0f);
        bus_write(1'b1, 5'h09, 2'b00, 16'h1111);
        bus_write(1'b1, 5'h0a, 2'b00, 16'h2222);
        bus_write(1'b1, 5'h0b, 2'b00, 16'h3333);
        bus_write(1'b1, 5'h0c, 2'b00, 16'h4444);
        bus_write(1'b1, 5'h0d, 2'b00, 16'hffea);
        check_word("layer_ctrl out", 16'h0f0f, ctrl.layer_ctrl);
        check_word("prio0 out", 16'h1111, ctrl.prio0);
        check_word("prio1 out", 16'h2222, ctrl.prio1);
        check_word("prio2 out", 16'h3333, ctrl.prio2);
        check_word("prio3 out", 16'h4444, ctrl.prio3);
        check_word("pal_page_en out", 16'h002a, {10'd0, ctrl.pal_page_en});
        chip_b_read(5'h08, rd);
        check_word("layer_ctrl read", 16'h0f0f, rd);
        chip_b_read(5'h0b, rd);
        check_word("prio2 read", 16'h3333, rd);
        chip_b_read(5'h0d, rd);
        check_word("pal_page read", 16'h002a, rd);
        chip_b_read(5'h19, rd);
        check_word("id read", 16'h050a, rd);
        check_word("mask0", 16'h0011, {8'd0, cfg.layer_mask0});
        check_word("mask1", 16'h0022, {8'd0, cfg.layer_mask1});
        check_word("mask2", 16'h0033, {8'd0, cfg.layer_mask2});
        check_word("mask3", 16'h0044, {8'd0, cfg.layer_mask3});
        check_word("mask4", 16'h0044, {8'd0, cfg.layer_mask4});
        check_word("game", 16'h002b, {10'd0, cfg.game});
        check_word("bank_offset", 16'h1234, cfg.bank_offset);
        check_word("bank_mask", 16'h0ff0, cfg.bank_mask);
        chip_b_read(5'h10, rd);
        check_word("unmapped read", open_bus, rd);
        // ID moved to word 0x1f, which the decode must never match
        chain[0] = 8'h3e;
        load_chain();
        chip_b_read(5'h1f, rd);
        check_word("0x1f read", open_bus, rd);
        end_test();

        begin_test("chip_b_partial");
        bus_write(1'b1, 5'h09, 2'b01, 16'h5555);
        bus_write(1'b1, 5'h09, 2'b10, 16'h6666);
        bus_write(1'b1, 5'h09, 2'b11, 16'h7777);
        check_word("prio0 kept", 16'h1111, ctrl.prio0);
        chip_b_read(5'h09, rd);
        check_word("prio0 read", 16'h1111, rd);
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // overall limit in case a task stalls
    initial begin
        #200000;
        $display("timeout: simulation did not finish in time");
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- vid_mmr.f
logic/vid_mmr_pkg.sv
logic/cpsb_addr_map.sv
logic/cpsa_regs.sv
logic/cpsb_regs.sv
logic/cpsb_read_mux.sv
logic/vid_mmr.sv
verification/vid_mmr_tb.sv
